// ==== logic/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    // data memory geometry
    localparam int DATA_RAM_WORDS = 256;
    localparam int RAM_ADDR_W     = 8;

    // iterations of the shift-add multiplier, one multiplier bit each
    localparam int MUL_CYCLES     = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD     = 4'd0,
        ALU_SUB     = 4'd1,
        ALU_SLT     = 4'd2,
        ALU_SLTU    = 4'd3,
        ALU_AND     = 4'd4,
        ALU_OR      = 4'd5,
        ALU_NOR     = 4'd6,
        ALU_XOR     = 4'd7,
        ALU_SLL     = 4'd8,
        ALU_SRL     = 4'd9,
        ALU_SRA     = 4'd10,
        ALU_LU12I   = 4'd11,
        // multi-cycle group
        ALU_MUL_W   = 4'd12,
        ALU_MULH_W  = 4'd13,
        ALU_MULH_WU = 4'd14
    } alu_op_t;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_RUN  = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_t;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu import exe_pkg::*; (
    input  wire          clk,
    input  wire          resetn,
    input  wire          alu_start,
    input  wire alu_op_t alu_op,
    input  wire word_t   alu_src1,
    input  wire word_t   alu_src2,
    output word_t        alu_result,
    output logic         alu_complete
);

    mul_state_t                      state;
    logic [$clog2(MUL_CYCLES)-1:0]   cnt;
    logic [63:0]                     acc;
    logic [63:0]                     mcand;
    word_t                           mplier;
    logic                            neg;

    logic        is_mul;
    logic        src1_neg;
    logic        src2_neg;
    word_t       mag1;
    word_t       mag2;
    logic [63:0] product;

    logic        do_sub;
    word_t       addend;
    word_t       sum;
    logic        carry;
    logic        slt;
    logic        sltu;
    word_t       comb_result;

    assign is_mul = alu_op inside {ALU_MUL_W, ALU_MULH_W, ALU_MULH_WU};

    // shared adder, sub and compares use a + ~b + 1
    assign do_sub = alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign addend = do_sub ? ~alu_src2 : alu_src2;
    assign {carry, sum} = {1'b0, alu_src1} + {1'b0, addend} + {32'b0, do_sub};

    // signed less-than from sign bits and difference sign
    assign slt  = (alu_src1[31] & ~alu_src2[31])
                | (~(alu_src1[31] ^ alu_src2[31]) & sum[31]);
    // no carry out means a borrow
    assign sltu = ~carry;

    always_comb begin
        case (alu_op)
            ALU_ADD,
            ALU_SUB:   comb_result = sum;
            ALU_SLT:   comb_result = {31'b0, slt};
            ALU_SLTU:  comb_result = {31'b0, sltu};
            ALU_AND:   comb_result = alu_src1 & alu_src2;
            ALU_OR:    comb_result = alu_src1 | alu_src2;
            ALU_NOR:   comb_result = ~(alu_src1 | alu_src2);
            ALU_XOR:   comb_result = alu_src1 ^ alu_src2;
            ALU_SLL:   comb_result = alu_src1 << alu_src2[4:0];
            ALU_SRL:   comb_result = alu_src1 >> alu_src2[4:0];
            ALU_SRA:   comb_result = word_t'($signed(alu_src1) >>> alu_src2[4:0]);
            // 20-bit immediate arrives right-aligned in src2
            ALU_LU12I: comb_result = {alu_src2[19:0], 12'h000};
            default:   comb_result = sum;
        endcase
    end

    // only mulh_w is signed, the low half does not depend on sign
    assign src1_neg = (alu_op == ALU_MULH_W) && alu_src1[31];
    assign src2_neg = (alu_op == ALU_MULH_W) && alu_src2[31];
    assign mag1     = src1_neg ? -alu_src1 : alu_src1;
    assign mag2     = src2_neg ? -alu_src2 : alu_src2;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= MUL_IDLE;
            cnt   <= '0;
        end else if (alu_start) begin
            state <= is_mul ? MUL_RUN : MUL_IDLE;
            cnt   <= '0;
        end else if (state == MUL_RUN) begin
            cnt <= cnt + 1'b1;
            if (cnt == MUL_CYCLES - 1) begin
                state <= MUL_DONE;
            end
        end
    end

    // unsigned shift-add over magnitudes
    always_ff @(posedge clk) begin
        if (alu_start) begin
            acc    <= '0;
            mcand  <= {32'b0, mag1};
            mplier <= mag2;
            neg    <= src1_neg ^ src2_neg;
        end else if (state == MUL_RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // sign fix for mulh_w
    assign product = neg ? (~acc + 64'd1) : acc;

    always_comb begin
        if (!is_mul) begin
            alu_result = comb_result;
        end else if (alu_op == ALU_MUL_W) begin
            alu_result = product[31:0];
        end else begin
            alu_result = product[63:32];
        end
    end

    // a multiply is not complete in its own start cycle
    assign alu_complete = is_mul ? (state == MUL_DONE && !alu_start)
                                 : (state != MUL_RUN);

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_ram import exe_pkg::*; (
    input  wire                   clk,
    input  wire                   ram_en,
    input  wire                   ram_we,
    input  wire [RAM_ADDR_W-1:0]  ram_addr,
    input  wire word_t            ram_wdata,
    output word_t                 ram_rdata
);

    word_t mem [DATA_RAM_WORDS];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (ram_en) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/exe_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exe_stage import exe_pkg::*; (
    input  wire                    clk,
    input  wire                    resetn,
    // decode side
    input  wire                    ds_valid,
    output logic                   es_allowin,
    input  wire alu_op_t           ds_alu_op,
    input  wire word_t             ds_alu_src1,
    input  wire word_t             ds_alu_src2,
    input  wire word_t             ds_rkd_value,
    input  wire                    ds_res_from_mem,
    input  wire                    ds_mem_we,
    input  wire                    ds_rf_we,
    input  wire reg_addr_t         ds_rf_waddr,
    input  wire word_t             ds_pc,
    // memory stage side
    input  wire                    ms_allowin,
    output logic                   es2ms_valid,
    output logic                   es_res_from_mem,
    output logic                   es_rf_we,
    output reg_addr_t              es_rf_waddr,
    output word_t                  es_result,
    output word_t                  es_pc,
    // data ram
    output logic                   ram_en,
    output logic                   ram_we,
    output logic [RAM_ADDR_W-1:0]  ram_addr,
    output word_t                  ram_wdata
);

    logic     es_valid;
    logic     alu_start;
    logic     alu_complete;
    logic     ds_fire;
    logic     es_fire;

    alu_op_t  alu_op_r;
    word_t    alu_src1_r;
    word_t    alu_src2_r;
    word_t    rkd_value_r;
    logic     res_from_mem_r;
    logic     mem_we_r;
    logic     rf_we_r;

    assign es_allowin  = !es_valid || (alu_complete && ms_allowin);
    assign es2ms_valid = es_valid && alu_complete;
    assign ds_fire     = ds_valid && es_allowin;
    assign es_fire     = es2ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid  <= 1'b0;
            alu_start <= 1'b0;
        end else begin
            if (es_allowin) begin
                es_valid <= ds_valid;
            end
            // kick the alu once per latched instruction
            alu_start <= ds_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_fire) begin
            alu_op_r       <= ds_alu_op;
            alu_src1_r     <= ds_alu_src1;
            alu_src2_r     <= ds_alu_src2;
            rkd_value_r    <= ds_rkd_value;
            res_from_mem_r <= ds_res_from_mem;
            mem_we_r       <= ds_mem_we;
            rf_we_r        <= ds_rf_we;
            es_rf_waddr    <= ds_rf_waddr;
            es_pc          <= ds_pc;
        end
    end

    alu u_alu (
        .clk          (clk),
        .resetn       (resetn),
        .alu_start    (alu_start),
        .alu_op       (alu_op_r),
        .alu_src1     (alu_src1_r),
        .alu_src2     (alu_src2_r),
        .alu_result   (es_result),
        .alu_complete (alu_complete)
    );

    assign es_res_from_mem = es_valid && res_from_mem_r;
    assign es_rf_we        = es_valid && rf_we_r;

    // loads may re-read while stalled, stores write only on the transfer
    assign ram_en    = es2ms_valid && (res_from_mem_r || mem_we_r);
    assign ram_we    = es_fire && mem_we_r;
    assign ram_addr  = es_result[RAM_ADDR_W+1:2];
    assign ram_wdata = rkd_value_r;

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage import exe_pkg::*; (
    input  wire             clk,
    input  wire             resetn,
    // execute side
    input  wire             es2ms_valid,
    output logic            ms_allowin,
    input  wire             es_res_from_mem,
    input  wire             es_rf_we,
    input  wire reg_addr_t  es_rf_waddr,
    input  wire word_t      es_result,
    input  wire word_t      es_pc,
    // data ram read port
    input  wire word_t      ram_rdata,
    // write-back side
    output logic            wb_valid,
    input  wire             wb_ready,
    output logic            wb_rf_we,
    output reg_addr_t       wb_rf_waddr,
    output word_t           wb_rf_wdata,
    output word_t           wb_pc
);

    logic   ms_valid;
    logic   ms_first;
    logic   ms_fire;

    logic   res_from_mem_r;
    logic   rf_we_r;
    word_t  result_r;
    word_t  load_data_r;
    word_t  load_data;

    assign ms_allowin = !ms_valid || wb_ready;
    assign ms_fire    = es2ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
            ms_first <= 1'b0;
        end else begin
            if (ms_allowin) begin
                ms_valid <= es2ms_valid;
            end
            // high only in the cycle right after entry
            ms_first <= ms_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_fire) begin
            res_from_mem_r <= es_res_from_mem;
            rf_we_r        <= es_rf_we;
            wb_rf_waddr    <= es_rf_waddr;
            result_r       <= es_result;
            wb_pc          <= es_pc;
        end
    end

    // ram output moves on later reads, keep our word
    always_ff @(posedge clk) begin
        if (ms_first) begin
            load_data_r <= ram_rdata;
        end
    end

    assign load_data   = ms_first ? ram_rdata : load_data_r;
    assign wb_valid    = ms_valid;
    assign wb_rf_we    = ms_valid && rf_we_r;
    assign wb_rf_wdata = res_from_mem_r ? load_data : result_r;

endmodule

`default_nettype wire

// ==== logic/exe_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module exe_pipe import exe_pkg::*; (
    input  wire             clk,
    input  wire             resetn,
    // decoded instruction in
    input  wire             ds_valid,
    output wire             es_allowin,
    input  wire alu_op_t    ds_alu_op,
    input  wire word_t      ds_alu_src1,
    input  wire word_t      ds_alu_src2,
    input  wire word_t      ds_rkd_value,
    input  wire             ds_res_from_mem,
    input  wire             ds_mem_we,
    input  wire             ds_rf_we,
    input  wire reg_addr_t  ds_rf_waddr,
    input  wire word_t      ds_pc,
    // write-back out
    input  wire             wb_ready,
    output wire             wb_valid,
    output wire             wb_rf_we,
    output wire reg_addr_t  wb_rf_waddr,
    output wire word_t      wb_rf_wdata,
    output wire word_t      wb_pc
);

    wire                    ms_allowin;
    wire                    es2ms_valid;
    wire                    es_res_from_mem;
    wire                    es_rf_we;
    wire reg_addr_t         es_rf_waddr;
    wire word_t             es_result;
    wire word_t             es_pc;

    wire                    ram_en;
    wire                    ram_we;
    wire [RAM_ADDR_W-1:0]   ram_addr;
    wire word_t             ram_wdata;
    wire word_t             ram_rdata;

    exe_stage u_exe_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ds_valid        (ds_valid),
        .es_allowin      (es_allowin),
        .ds_alu_op       (ds_alu_op),
        .ds_alu_src1     (ds_alu_src1),
        .ds_alu_src2     (ds_alu_src2),
        .ds_rkd_value    (ds_rkd_value),
        .ds_res_from_mem (ds_res_from_mem),
        .ds_mem_we       (ds_mem_we),
        .ds_rf_we        (ds_rf_we),
        .ds_rf_waddr     (ds_rf_waddr),
        .ds_pc           (ds_pc),
        .ms_allowin      (ms_allowin),
        .es2ms_valid     (es2ms_valid),
        .es_res_from_mem (es_res_from_mem),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .es_result       (es_result),
        .es_pc           (es_pc),
        .ram_en          (ram_en),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .resetn          (resetn),
        .es2ms_valid     (es2ms_valid),
        .ms_allowin      (ms_allowin),
        .es_res_from_mem (es_res_from_mem),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .es_result       (es_result),
        .es_pc           (es_pc),
        .ram_rdata       (ram_rdata),
        .wb_valid        (wb_valid),
        .wb_ready        (wb_ready),
        .wb_rf_we        (wb_rf_we),
        .wb_rf_waddr     (wb_rf_waddr),
        .wb_rf_wdata     (wb_rf_wdata),
        .wb_pc           (wb_pc)
    );

endmodule

`default_nettype wire

// ==== tests/tb_exe_tasks.svh ====
`ifndef TB_EXE_TASKS_SVH
`define TB_EXE_TASKS_SVH

// one expected write-back
typedef struct packed {
    logic        rf_we;
    reg_addr_t   waddr;
    word_t       wdata;
    word_t       pc;
    logic [31:0] due;
    logic        exact;
    logic        is_mul;
} exp_t;

exp_t exp_q [$];

// galois step with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// n bits from a stream, one step per bit
task automatic take_bits(inout logic [31:0] st, input int n, output word_t v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
        v  = {v[30:0], st[0]};
        st = lfsr_next(st);
    end
endtask

task automatic check_equal(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        err_count++;
        $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        $display("Done: errors found");
        $fatal(1);
    end
endtask

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
endtask

// expected result straight from the operation definitions
function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic        [63:0] prod_s;
    logic        [63:0] prod_u;
    logic        [63:0] sra_wide;
    sa       = $signed(a);
    sb       = $signed(b);
    prod_s   = sa * sb;
    prod_u   = {32'b0, a} * {32'b0, b};
    // sign-extend to 64 bits, then a plain right shift
    sra_wide = {{32{a[31]}}, a} >> b[4:0];
    case (op)
        ALU_ADD:     return a + b;
        ALU_SUB:     return a - b;
        ALU_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU:    return (a < b) ? 32'd1 : 32'd0;
        ALU_AND:     return a & b;
        ALU_OR:      return a | b;
        ALU_NOR:     return ~(a | b);
        ALU_XOR:     return a ^ b;
        ALU_SLL:     return a << b[4:0];
        ALU_SRL:     return a >> b[4:0];
        ALU_SRA:     return sra_wide[31:0];
        ALU_LU12I:   return {b[19:0], 12'h000};
        ALU_MUL_W:   return prod_u[31:0];
        ALU_MULH_W:  return prod_s[63:32];
        ALU_MULH_WU: return prod_u[63:32];
        default:     return 'x;
    endcase
endfunction

// offer one instruction and hold it until the stage takes it
task automatic issue(input alu_op_t op, input word_t src1, input word_t src2,
                     input word_t rkd, input logic load, input logic store,
                     input logic rf_we, input reg_addr_t waddr, input logic exact);
    exp_t                  e;
    word_t                 res;
    logic [RAM_ADDR_W-1:0] idx;
    res = ref_alu(op, src1, src2);
    idx = res[RAM_ADDR_W+1:2];
    @(negedge clk);
    ds_valid        = 1'b1;
    ds_alu_op       = op;
    ds_alu_src1     = src1;
    ds_alu_src2     = src2;
    ds_rkd_value    = rkd;
    ds_res_from_mem = load;
    ds_mem_we       = store;
    ds_rf_we        = rf_we;
    ds_rf_waddr     = waddr;
    ds_pc           = next_pc;
    #SETTLE;
    while (!es_allowin) begin
        @(negedge clk);
        #SETTLE;
    end
    e.rf_we  = rf_we;
    e.waddr  = waddr;
    e.pc     = next_pc;
    e.wdata  = load ? shadow[idx] : res;
    e.is_mul = op inside {ALU_MUL_W, ALU_MULH_W, ALU_MULH_WU};
    e.due    = cycle + (e.is_mul ? MUL_CYCLES + 2 : 2);
    e.exact  = exact && !e.is_mul;
    if (store) begin
        shadow[idx] = rkd;
        written_q.push_back(idx);
    end
    exp_q.push_back(e);
    next_pc = next_pc + 32'd4;
    @(posedge clk);
endtask

task automatic drain();
    @(negedge clk);
    ds_valid = 1'b0;
    while (exp_q.size() != 0) begin
        @(negedge clk);
    end
endtask

// called before the edge on which wb_valid and wb_ready are both high
task automatic retire_wb();
    exp_t e;
    if (exp_q.size() == 0) begin
        abort_run("write-back seen with no instruction outstanding");
    end else begin
        e = exp_q.pop_front();
        check_equal(wb_pc, e.pc, "wb_pc");
        check_equal(wb_rf_we, e.rf_we, "wb_rf_we");
        check_equal(wb_rf_waddr, e.waddr, "wb_rf_waddr");
        if (e.rf_we) begin
            check_equal(wb_rf_wdata, e.wdata, "wb_rf_wdata");
        end
        if (e.exact) begin
            check_equal(cycle, e.due, "write-back cycle");
        end else if (e.is_mul && cycle < e.due) begin
            abort_run("multiply write-back arrived before its iterations were done");
        end
    end
endtask

`endif

// ==== tests/tb_exe_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exe_pipe import exe_pkg::*; ();

    localparam int          CLK_PERIOD   = 8;
    localparam int          SETTLE       = 1;
    localparam int          RESET_CYCLES = 5;
    localparam int          IDLE_CYCLES  = 10;
    localparam logic [31:0] LFSR_SEED    = 32'h7be4;

    localparam int ALONE_PER_OP = 2;
    localparam int SINGLE_BURST = 24;
    localparam int MUL_CORNER   = 27;
    localparam int MUL_RANDOM   = 3;
    localparam int STORE_COUNT  = 12;
    localparam int PAIR_COUNT   = 4;
    localparam int MIXED_COUNT  = 40;

    localparam int TOTAL_INSTR = 12 * ALONE_PER_OP + SINGLE_BURST + MUL_CORNER
                               + 3 * MUL_RANDOM * 2 + 2 * STORE_COUNT + 2 * PAIR_COUNT
                               + MIXED_COUNT;
    localparam int TIMEOUT_CYCLES = TOTAL_INSTR * (MUL_CYCLES + 8) + RESET_CYCLES;

    logic       clk;
    logic       resetn;
    logic       ds_valid;
    logic       es_allowin;
    alu_op_t    ds_alu_op;
    word_t      ds_alu_src1;
    word_t      ds_alu_src2;
    word_t      ds_rkd_value;
    logic       ds_res_from_mem;
    logic       ds_mem_we;
    logic       ds_rf_we;
    reg_addr_t  ds_rf_waddr;
    word_t      ds_pc;
    logic       wb_ready;
    logic       wb_valid;
    logic       wb_rf_we;
    reg_addr_t  wb_rf_waddr;
    word_t      wb_rf_wdata;
    word_t      wb_pc;

    logic [31:0]           cycle = '0;
    int                    err_count;
    logic [31:0]           op_lfsr;
    logic [31:0]           stall_lfsr;
    logic                  ready_random;
    word_t                 next_pc;
    word_t                 shadow [DATA_RAM_WORDS];
    logic [RAM_ADDR_W-1:0] written_q [$];

    `include "tb_exe_tasks.svh"

    exe_pipe dut0 (
        .clk             (clk),
        .resetn          (resetn),
        .ds_valid        (ds_valid),
        .es_allowin      (es_allowin),
        .ds_alu_op       (ds_alu_op),
        .ds_alu_src1     (ds_alu_src1),
        .ds_alu_src2     (ds_alu_src2),
        .ds_rkd_value    (ds_rkd_value),
        .ds_res_from_mem (ds_res_from_mem),
        .ds_mem_we       (ds_mem_we),
        .ds_rf_we        (ds_rf_we),
        .ds_rf_waddr     (ds_rf_waddr),
        .ds_pc           (ds_pc),
        .wb_ready        (wb_ready),
        .wb_valid        (wb_valid),
        .wb_rf_we        (wb_rf_we),
        .wb_rf_waddr     (wb_rf_waddr),
        .wb_rf_wdata     (wb_rf_wdata),
        .wb_pc           (wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        abort_run("timeout: the tests did not finish within the cycle limit");
    end

    // drives wb_ready and checks each write-back handshake
    initial begin : collect
        word_t r;
        logic  held;
        word_t held_pc;
        word_t held_wdata;
        held       = 1'b0;
        held_pc    = '0;
        held_wdata = '0;
        forever begin
            @(negedge clk);
            if (ready_random) begin
                take_bits(stall_lfsr, 1, r);
                wb_ready = r[0];
            end else begin
                wb_ready = 1'b1;
            end
            #SETTLE;
            // outputs frozen since the last stalled cycle
            if (held) begin
                check_equal(wb_valid, 1'b1, "wb_valid while stalled");
                check_equal(wb_pc, held_pc, "wb_pc while stalled");
                check_equal(wb_rf_wdata, held_wdata, "wb_rf_wdata while stalled");
            end
            held = 1'b0;
            if (resetn && wb_valid) begin
                if (wb_ready) begin
                    retire_wb();
                end else begin
                    held       = 1'b1;
                    held_pc    = wb_pc;
                    held_wdata = wb_rf_wdata;
                end
            end
        end
    end

    task automatic idle_after_reset();
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            #SETTLE;
            check_equal(wb_valid, 1'b0, "wb_valid while idle");
            check_equal(es_allowin, 1'b1, "es_allowin while idle");
        end
    endtask

    task automatic single_cycle_ops();
        word_t a;
        word_t b;
        word_t w;
        int    k;
        for (k = 0; k < 12; k++) begin
            repeat (ALONE_PER_OP) begin
                take_bits(op_lfsr, 32, a);
                take_bits(op_lfsr, 32, b);
                take_bits(op_lfsr, 5, w);
                issue(alu_op_t'(k), a, b, '0, 1'b0, 1'b0, 1'b1, w[4:0], 1'b1);
                drain();
            end
        end
        // back to back at one per cycle
        repeat (SINGLE_BURST) begin
            take_bits(op_lfsr, 32, a);
            take_bits(op_lfsr, 32, b);
            take_bits(op_lfsr, 32, w);
            issue(alu_op_t'(w[31:8] % 12), a, b, '0, 1'b0, 1'b0, 1'b1, w[4:0], 1'b1);
        end
        drain();
    endtask

    task automatic multiply_ops();
        word_t corner [3];
        word_t a;
        word_t b;
        word_t w;
        int    m;
        int    i;
        int    j;
        corner[0] = 32'h0000_0000;
        corner[1] = 32'hffff_ffff;
        corner[2] = 32'h8000_0000;
        for (m = 0; m < 3; m++) begin
            for (i = 0; i < 3; i++) begin
                for (j = 0; j < 3; j++) begin
                    issue(alu_op_t'(int'(ALU_MUL_W) + m), corner[i], corner[j], '0,
                          1'b0, 1'b0, 1'b1, reg_addr_t'(i * 3 + j), 1'b0);
                end
            end
        end
        drain();
        // a single-cycle op queued right behind each multiply
        for (m = 0; m < 3; m++) begin
            repeat (MUL_RANDOM) begin
                take_bits(op_lfsr, 32, a);
                take_bits(op_lfsr, 32, b);
                take_bits(op_lfsr, 32, w);
                issue(alu_op_t'(int'(ALU_MUL_W) + m), a, b, '0,
                      1'b0, 1'b0, 1'b1, w[4:0], 1'b0);
                issue(alu_op_t'(w[31:8] % 12), b, a, '0,
                      1'b0, 1'b0, 1'b1, w[12:8], 1'b0);
            end
        end
        drain();
    endtask

    task automatic store_then_load();
        word_t base [STORE_COUNT];
        word_t off  [STORE_COUNT];
        word_t d;
        word_t w;
        int    i;
        for (i = 0; i < STORE_COUNT; i++) begin
            take_bits(op_lfsr, 32, base[i]);
            take_bits(op_lfsr, 32, off[i]);
            take_bits(op_lfsr, 32, d);
            issue(ALU_ADD, base[i], off[i], d, 1'b0, 1'b1, 1'b0, '0, 1'b0);
        end
        for (i = 0; i < STORE_COUNT; i++) begin
            take_bits(op_lfsr, 5, w);
            issue(ALU_ADD, base[i], off[i], '0, 1'b1, 1'b0, 1'b1, w[4:0], 1'b0);
        end
        // load directly behind the store to the same word
        repeat (PAIR_COUNT) begin
            take_bits(op_lfsr, 32, base[0]);
            take_bits(op_lfsr, 32, off[0]);
            take_bits(op_lfsr, 32, d);
            issue(ALU_ADD, base[0], off[0], d, 1'b0, 1'b1, 1'b0, '0, 1'b0);
            issue(ALU_ADD, base[0], off[0], '0, 1'b1, 1'b0, 1'b1, d[4:0], 1'b0);
        end
        drain();
    endtask

    task automatic mixed_with_stalls();
        word_t                 a;
        word_t                 b;
        word_t                 w;
        logic [RAM_ADDR_W-1:0] k;
        int                    n;
        ready_random = 1'b1;
        for (n = 0; n < MIXED_COUNT; n++) begin
            take_bits(op_lfsr, 32, a);
            take_bits(op_lfsr, 32, b);
            take_bits(op_lfsr, 32, w);
            case (w[1:0])
                2'd0: issue(alu_op_t'(w[31:8] % 12), a, b, '0,
                            1'b0, 1'b0, 1'b1, w[6:2], 1'b0);
                2'd1: issue(alu_op_t'(int'(ALU_MUL_W) + int'(w[9:8] % 3)), a, b, '0,
                            1'b0, 1'b0, 1'b1, w[6:2], 1'b0);
                2'd2: issue(ALU_ADD, a, b, w, 1'b0, 1'b1, 1'b0, '0, 1'b0);
                default: begin
                    // only words that were stored before
                    k = written_q[w[31:8] % written_q.size()];
                    issue(ALU_ADD, {a[29-RAM_ADDR_W:0], k, 2'b00}, '0, '0,
                          1'b1, 1'b0, 1'b1, w[6:2], 1'b0);
                end
            endcase
        end
        drain();
        ready_random = 1'b0;
    endtask

    initial begin
        resetn          = 1'b0;
        ds_valid        = 1'b0;
        ds_alu_op       = ALU_ADD;
        ds_alu_src1     = '0;
        ds_alu_src2     = '0;
        ds_rkd_value    = '0;
        ds_res_from_mem = 1'b0;
        ds_mem_we       = 1'b0;
        ds_rf_we        = 1'b0;
        ds_rf_waddr     = '0;
        ds_pc           = '0;
        wb_ready        = 1'b1;
        err_count       = 0;
        op_lfsr         = LFSR_SEED;
        stall_lfsr      = LFSR_SEED;
        ready_random    = 1'b0;
        next_pc         = 32'h1c00_0000;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        idle_after_reset();
        single_cycle_ops();
        multiply_ops();
        store_then_load();
        mixed_with_stalls();

        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== exe_pipe.f ====
+incdir+tests
logic/exe_pkg.sv
logic/alu.sv
logic/data_ram.sv
logic/exe_stage.sv
logic/mem_stage.sv
logic/exe_pipe.sv
tests/tb_exe_pipe.sv

// ==== Bender.yml ====
package:
  name: exe_pipe

sources:
  - files:
      - logic/exe_pkg.sv
      - logic/alu.sv
      - logic/data_ram.sv
      - logic/exe_stage.sv
      - logic/mem_stage.sv
      - logic/exe_pipe.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_exe_pipe.sv
